/* build.f */
+incdir+sim
verilog/ittage_pkg.sv
verilog/ittage_update_if.sv
verilog/ittage_hash.sv
verilog/ittage_bank.sv
verilog/ittage_select.sv
verilog/ittage_update.sv
verilog/ittage.sv
sim/ittage_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the ITTAGE testbench with Verilator, runs it and checks the result line.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f build.f --top-module ittage_tb -o ittage_sim \
    && ./obj_dir/ittage_sim | tee /dev/stderr | grep -F "Simulation finished: PASS" > /dev/null \
    && echo "Run passed" \
    || { echo "Run failed"; exit 1; }

/* sim/ittage_tb_tasks.svh */
task automatic count_error();
    errors++;
    test_errors++;
endtask

task automatic finish_test(input string name);
    tests_run++;
    $display("Test %0d, %s: %0d error(s)", tests_run, name, test_errors);
    test_errors = 0;
endtask

// Called right after a rising edge; returns on the edge after pred_valid.
task automatic send_lookup(input logic [PC_W-1:0] pc);
    lookup_pc    <= pc;
    lookup_valid <= 1'b1;
    @(posedge clk);
    lookup_valid <= 1'b0;
    got_latency = 0;
    do begin
        @(negedge clk);
        got_latency++;
    end while (!pred_valid && got_latency < 8);
    if (!pred_valid) begin
        $display("No prediction came back within 8 cycles of the lookup at %0t", $time);
        count_error();
    end
    got_hit    = pred_hit;
    got_target = pred_target;
    got_meta   = pred_meta;
    @(posedge clk);
endtask

task automatic send_update(input logic [PC_W-1:0] pc, input ittage_pkg::br_kind_e kind,
                           input logic taken, input logic [PC_W-1:0] target,
                           input ittage_pkg::ittage_meta_t meta);
    update_pc     <= pc;
    update_kind   <= kind;
    update_taken  <= taken;
    update_target <= target;
    update_meta   <= meta;
    update_valid  <= 1'b1;
    @(posedge clk);
    update_valid <= 1'b0;
    repeat (2) @(posedge clk);  // Lets a usefulness clear land before the next lookup.
endtask

task automatic check_pred(input logic exp_hit, input logic [PC_W-1:0] exp_target);
    checks++;
    if (got_hit !== exp_hit || got_target !== exp_target) begin
        $display("Fail %0t: prediction hit %0b target %h, expected hit %0b target %h",
                 $time, got_hit, got_target, exp_hit, exp_target);
        count_error();
    end
endtask

task automatic check_meta(input ittage_pkg::ittage_meta_t exp);
    checks++;
    if (got_meta !== exp) begin
        $display("Fail %0t: meta %b/%0d/%h/%h/%b, expected %b/%0d/%h/%h/%b", $time,
                 got_meta.provider, got_meta.ctr, got_meta.offset, got_meta.alt_offset,
                 got_meta.u_busy, exp.provider, exp.ctr, exp.offset, exp.alt_offset,
                 exp.u_busy);
        count_error();
    end
endtask

task automatic probe(input logic [PC_W-1:0] pc);
    logic            exp_hit;
    logic [PC_W-1:0] exp_target;
    model_predict(exp_hit, exp_target, exp_meta);
    send_lookup(pc);
    check_pred(exp_hit, exp_target);
    check_meta(exp_meta);
endtask

// The update returns the metadata that the lookup just handed out.
task automatic train_step(input logic [PC_W-1:0] pc, input logic [OFF_W-1:0] off,
                          input ittage_pkg::br_kind_e kind, input logic taken);
    probe(pc);
    send_update(pc, kind, taken, to_target(off), got_meta);
    model_update(off, kind, taken, exp_meta);
endtask

task automatic test_after_reset();
    logic [PC_W-1:0] pc;
    pc = make_pc(6'd1);
    new_row();
    probe(pc);
    if (got_latency != 2) begin
        $display("Fail %0t: the prediction came %0d cycles after the lookup instead of 2",
                 $time, got_latency);
        count_error();
    end
    finish_test("after reset");
endtask

task automatic test_first_alloc();
    logic [PC_W-1:0]  pc;
    logic [OFF_W-1:0] t1;
    pc = make_pc(6'd2);
    t1 = make_offset('0);
    new_row();
    train_step(pc, t1, ittage_pkg::BR_INDIRECT, 1'b1);
    probe(pc);
    finish_test("first allocation");
endtask

task automatic test_confidence();
    logic [PC_W-1:0]  pc;
    logic [OFF_W-1:0] t1;
    logic [OFF_W-1:0] t2;
    pc = make_pc(6'd3);
    t1 = make_offset('0);
    t2 = make_offset(t1);
    new_row();
    for (int i = 0; i < 4; i++) begin
        train_step(pc, t1, ittage_pkg::BR_INDIRECT, 1'b1);
    end
    for (int i = 0; i < 4; i++) begin
        train_step(pc, (i % 2 == 0) ? t2 : t1, ittage_pkg::BR_INDIRECT, 1'b1);  // Each one misses.
    end
    probe(pc);
    finish_test("confidence and replacement");
endtask

task automatic test_longer_history();
    logic [PC_W-1:0]  pc;
    logic [OFF_W-1:0] t1;
    logic [OFF_W-1:0] t2;
    pc = make_pc(6'd4);
    t1 = make_offset('0);
    t2 = make_offset(t1);
    new_row();
    train_step(pc, t1, ittage_pkg::BR_INDIRECT, 1'b1);
    train_step(pc, t1, ittage_pkg::BR_INDIRECT, 1'b1);
    train_step(pc, t2, ittage_pkg::BR_INDIRECT, 1'b1);
    probe(pc);
    finish_test("longer history wins");
endtask

task automatic test_ignored_kinds();
    logic [PC_W-1:0]  pc;
    logic [OFF_W-1:0] t1;
    logic [OFF_W-1:0] t2;
    pc = make_pc(6'd5);
    t1 = make_offset('0);
    t2 = make_offset(t1);
    new_row();
    train_step(pc, t1, ittage_pkg::BR_IND_CALL, 1'b1);
    train_step(pc, t2, ittage_pkg::BR_COND, 1'b1);
    train_step(pc, t2, ittage_pkg::BR_DIRECT, 1'b1);
    train_step(pc, t2, ittage_pkg::BR_RETURN, 1'b1);
    train_step(pc, t2, ittage_pkg::BR_INDIRECT, 1'b0);
    probe(pc);
    finish_test("non-indirect updates ignored");
endtask

/* sim/ittage_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module ittage_tb;

    localparam int NUM_BANKS    = ittage_pkg::NUM_BANKS;
    localparam int PC_W         = ittage_pkg::PC_BITS;
    localparam int OFF_W        = ittage_pkg::OFFSET_BITS;
    localparam int RESETU_MAX   = (1 << ittage_pkg::RESETU_BITS) - 1;
    localparam int RESET_CYCLES = 8;
    localparam int LOOKUPS      = 22;
    localparam int UPDATES      = 17;
    localparam int MAX_CYCLES   = RESET_CYCLES + LOOKUPS * 4 + UPDATES * 3 + 100;

    logic                              clk;
    logic                              rst;
    logic                              lookup_valid;
    logic [PC_W-1:0]                   lookup_pc;
    logic [ittage_pkg::GHIST_BITS-1:0] lookup_ghist;
    logic                              update_valid;
    logic [PC_W-1:0]                   update_pc;
    logic [ittage_pkg::GHIST_BITS-1:0] update_ghist;
    ittage_pkg::br_kind_e              update_kind;
    logic                              update_taken;
    logic [PC_W-1:0]                   update_target;
    ittage_pkg::ittage_meta_t          update_meta;
    logic                              pred_valid;
    logic                              pred_hit;
    logic [PC_W-1:0]                   pred_target;
    ittage_pkg::ittage_meta_t          pred_meta;

    logic                              got_hit;     // Prediction captured from the last lookup.
    logic [PC_W-1:0]                   got_target;
    ittage_pkg::ittage_meta_t          got_meta;
    ittage_pkg::ittage_meta_t          exp_meta;
    int                                got_latency;
    logic [15:0]                       lfsr;
    logic [ittage_pkg::GHIST_BITS-1:0] hist;
    int                                cycles;
    int                                errors;
    int                                checks;
    int                                test_errors;
    int                                tests_run;

    // Reference state of the single row that the current test uses in each bank.
    logic                              m_valid [NUM_BANKS];
    logic [ittage_pkg::CTR_BITS-1:0]   m_ctr   [NUM_BANKS];
    logic [ittage_pkg::U_BITS-1:0]     m_u     [NUM_BANKS];
    logic [OFF_W-1:0]                  m_off   [NUM_BANKS];
    int                                m_resetu;

    ittage UUT (
        .clk           (clk),
        .rst           (rst),
        .lookup_valid  (lookup_valid),
        .lookup_pc     (lookup_pc),
        .lookup_ghist  (lookup_ghist),
        .update_valid  (update_valid),
        .update_pc     (update_pc),
        .update_ghist  (update_ghist),
        .update_kind   (update_kind),
        .update_taken  (update_taken),
        .update_target (update_target),
        .update_meta   (update_meta),
        .pred_valid    (pred_valid),
        .pred_hit      (pred_hit),
        .pred_target   (pred_target),
        .pred_meta     (pred_meta)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Taps 16, 14, 13 and 11; one step per bit drawn.
    function automatic logic [31:0] draw(input int nbits);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < nbits; i++) begin
            fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    // The slot lands on the index bits, so every test owns its own row.
    function automatic logic [PC_W-1:0] make_pc(input logic [5:0] slot);
        logic [31:0] r;
        r = draw(PC_W - 7);
        return {r[PC_W-8:0], slot, 1'b0};
    endfunction

    function automatic logic [OFF_W-1:0] make_offset(input logic [OFF_W-1:0] avoid);
        logic [31:0]      r;
        logic [OFF_W-1:0] off;
        r   = draw(OFF_W - 1);
        off = {r[OFF_W-2:0], 1'b1};
        if (off == avoid) begin
            off[1] = ~off[1];
        end
        return off;
    endfunction

    function automatic logic [PC_W-1:0] to_target(input logic [OFF_W-1:0] off);
        return {{(PC_W - OFF_W - 1){1'b0}}, off, 1'b0};
    endfunction

    task automatic new_row();
        for (int b = 0; b < NUM_BANKS; b++) begin
            m_valid[b] = 1'b0;
            m_ctr[b]   = '0;
            m_u[b]     = '0;
            m_off[b]   = '0;
        end
    endtask

    task automatic model_predict(output logic hit, output logic [PC_W-1:0] target,
                                 output ittage_pkg::ittage_meta_t m);
        logic found;
        logic alt_found;
        found     = 1'b0;
        alt_found = 1'b0;
        m         = '0;
        for (int b = NUM_BANKS - 1; b >= 0; b--) begin
            m.u_busy[b] = (m_u[b] != '0);
            if (m_valid[b] && !found) begin
                found         = 1'b1;
                m.provider[b] = 1'b1;
                m.ctr         = m_ctr[b];
                m.offset      = m_off[b];
            end else if (m_valid[b] && !alt_found) begin
                alt_found    = 1'b1;
                m.alt_offset = m_off[b];
            end
        end
        hit    = found;
        target = to_target(m.offset);
    endtask

    task automatic model_update(input logic [OFF_W-1:0] tgt, input ittage_pkg::br_kind_e kind,
                                input logic taken, input ittage_pkg::ittage_meta_t meta);
        int   p;
        int   busy;
        logic perr;
        logic aerr;
        logic placed;
        p      = -1;
        busy   = 0;
        placed = 1'b0;
        perr   = (tgt != meta.offset);
        aerr   = (tgt != meta.alt_offset);
        if (!taken || !(kind == ittage_pkg::BR_INDIRECT || kind == ittage_pkg::BR_IND_CALL)) begin
            return;
        end
        for (int b = 0; b < NUM_BANKS; b++) begin
            if (meta.provider[b]) begin
                p = b;
            end
            if (meta.u_busy[b]) begin
                busy++;
            end
        end
        if (p >= 0) begin
            if (!perr) begin
                m_ctr[p] = (meta.ctr == '1) ? meta.ctr : meta.ctr + 1'b1;
            end else begin
                m_ctr[p] = (meta.ctr == '0) ? meta.ctr : meta.ctr - 1'b1;
            end
            if (m_ctr[p] == '0) begin
                m_off[p] = tgt;  // Confidence is gone, so the target is replaced.
            end
            if (perr != aerr) begin
                m_u[p] = perr ? '0 : {1'b0, meta.u_busy[p]} + 1'b1;
            end
        end
        for (int b = 0; b < NUM_BANKS; b++) begin
            if (perr && !placed && b > p && !meta.u_busy[b]) begin
                placed     = 1'b1;
                m_valid[b] = 1'b1;
                m_ctr[b]   = 1;
                m_off[b]   = tgt;
                m_u[b]     = '0;
            end
        end
        if (perr) begin
            m_resetu = (busy < NUM_BANKS / 2) ? (m_resetu + RESETU_MAX) % (RESETU_MAX + 1)
                                              : (m_resetu + 1) % (RESETU_MAX + 1);
            if (m_resetu == RESETU_MAX) begin
                m_resetu = 0;
                for (int b = 0; b < NUM_BANKS; b++) begin
                    m_u[b] = '0;
                end
            end
        end
    endtask

    `include "ittage_tb_tasks.svh"

    initial begin
        cycles = 0;
        while (cycles < MAX_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial begin
        errors        = 0;
        checks        = 0;
        test_errors   = 0;
        tests_run     = 0;
        m_resetu      = 0;
        lfsr          = 16'd34;
        hist[63:32]   = draw(32);
        hist[31:0]    = draw(32);
        rst           = 1'b1;
        lookup_valid  = 1'b0;
        lookup_pc     = '0;
        lookup_ghist  = hist;  // One history for the whole run keeps the rows apart.
        update_valid  = 1'b0;
        update_pc     = '0;
        update_ghist  = hist;
        update_kind   = ittage_pkg::BR_COND;
        update_taken  = 1'b0;
        update_target = '0;
        update_meta   = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        test_after_reset();
        test_first_alloc();
        test_confidence();
        test_longer_history();
        test_ignored_kinds();
        $display("Tests: %0d, checks: %0d, errors: %0d", tests_run, checks, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verilog/ittage.sv */
`timescale 1ns/100ps
`default_nettype none

module ittage #(
    parameter int                      NUM_BANKS = ittage_pkg::NUM_BANKS,
    parameter int                      SET_BITS  = 6,
    parameter logic [NUM_BANKS*16-1:0] HIST_LEN  = 64'h0020_0010_0008_0004
) (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              lookup_valid,
    input  logic [ittage_pkg::PC_BITS-1:0]    lookup_pc,
    input  logic [ittage_pkg::GHIST_BITS-1:0] lookup_ghist,
    input  logic                              update_valid,
    input  logic [ittage_pkg::PC_BITS-1:0]    update_pc,
    input  logic [ittage_pkg::GHIST_BITS-1:0] update_ghist,
    input  ittage_pkg::br_kind_e              update_kind,
    input  logic                              update_taken,
    input  logic [ittage_pkg::PC_BITS-1:0]    update_target,
    input  ittage_pkg::ittage_meta_t          update_meta,
    output logic                              pred_valid,
    output logic                              pred_hit,
    output logic [ittage_pkg::PC_BITS-1:0]    pred_target,
    output ittage_pkg::ittage_meta_t          pred_meta
);

    ittage_pkg::bank_entry_t [NUM_BANKS-1:0] entries;

    ittage_update_if #(.NUM_BANKS(NUM_BANKS)) upd_if ();

    generate
        for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
            logic [SET_BITS-1:0]             lk_idx;
            logic [SET_BITS-1:0]             up_idx;
            logic [ittage_pkg::TAG_BITS-1:0] lk_tag;
            logic [ittage_pkg::TAG_BITS-1:0] up_tag;

            ittage_hash #(
                .SET_BITS (SET_BITS),
                .HIST_LEN (HIST_LEN[b*16 +: 16])
            ) u_lookup_hash (
                .pc    (lookup_pc),
                .ghist (lookup_ghist),
                .idx   (lk_idx),
                .tag   (lk_tag)
            );

            ittage_hash #(
                .SET_BITS (SET_BITS),
                .HIST_LEN (HIST_LEN[b*16 +: 16])
            ) u_update_hash (
                .pc    (update_pc),
                .ghist (update_ghist),
                .idx   (up_idx),
                .tag   (up_tag)
            );

            ittage_bank #(
                .SET_BITS (SET_BITS),
                .BANK_ID  (b)
            ) u_bank (
                .clk    (clk),
                .rst    (rst),
                .rd_en  (lookup_valid),
                .rd_idx (lk_idx),
                .rd_tag (lk_tag),
                .upd    (upd_if.bank),
                .wr_idx (up_idx),
                .wr_tag (up_tag),
                .entry  (entries[b])
            );
        end
    endgenerate

    ittage_select #(.NUM_BANKS(NUM_BANKS)) u_select (
        .clk         (clk),
        .rst         (rst),
        .valid_in    (lookup_valid),
        .entries     (entries),
        .pred_valid  (pred_valid),
        .pred_hit    (pred_hit),
        .pred_target (pred_target),
        .pred_meta   (pred_meta)
    );

    ittage_update #(.NUM_BANKS(NUM_BANKS)) u_update (
        .clk           (clk),
        .rst           (rst),
        .update_valid  (update_valid),
        .update_kind   (update_kind),
        .update_taken  (update_taken),
        .update_target (update_target),
        .update_meta   (update_meta),
        .upd           (upd_if.policy)
    );

endmodule

`default_nettype wire

/* verilog/ittage_bank.sv */
`timescale 1ns/100ps
`default_nettype none

module ittage_bank #(
    parameter int SET_BITS = 6,
    parameter int BANK_ID  = 0
) (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            rd_en,
    input  logic [SET_BITS-1:0]             rd_idx,
    input  logic [ittage_pkg::TAG_BITS-1:0] rd_tag,
    ittage_update_if.bank                   upd,
    input  logic [SET_BITS-1:0]             wr_idx,
    input  logic [ittage_pkg::TAG_BITS-1:0] wr_tag,
    output ittage_pkg::bank_entry_t         entry
);

    localparam int ROWS = 1 << SET_BITS;

    logic [ittage_pkg::TAG_BITS-1:0]    tag_mem [ROWS];
    logic [ittage_pkg::CTR_BITS-1:0]    ctr_mem [ROWS];
    logic [ittage_pkg::OFFSET_BITS-1:0] off_mem [ROWS];
    logic [ittage_pkg::U_BITS-1:0]      u_mem   [ROWS];

    logic [ittage_pkg::TAG_BITS-1:0]    lk_tag_q;
    logic [ittage_pkg::TAG_BITS-1:0]    row_tag_q;
    logic [ittage_pkg::CTR_BITS-1:0]    row_ctr_q;
    logic [ittage_pkg::U_BITS-1:0]      row_u_q;
    logic [ittage_pkg::OFFSET_BITS-1:0] row_off_q;

    logic is_prov;
    logic is_alloc;
    logic ctr_zero;

    assign is_prov  = upd.wr_en & upd.provider[BANK_ID];
    assign is_alloc = upd.wr_en & upd.alloc[BANK_ID];
    assign ctr_zero = (upd.ctr_new[BANK_ID] == '0);

    always_ff @(posedge clk) begin
        if (rd_en) begin
            lk_tag_q  <= rd_tag;
            row_tag_q <= tag_mem[rd_idx];
            row_ctr_q <= ctr_mem[rd_idx];
            row_u_q   <= u_mem[rd_idx];
            row_off_q <= off_mem[rd_idx];
        end
    end

    assign entry.hit    = (row_tag_q != '0) && (row_tag_q == lk_tag_q);  // Empty rows never hit.
    assign entry.ctr    = row_ctr_q;
    assign entry.u      = row_u_q;
    assign entry.offset = row_off_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int r = 0; r < ROWS; r++) begin
                tag_mem[r] <= '0;
                ctr_mem[r] <= '0;
                off_mem[r] <= '0;
            end
        end else begin
            if (is_prov || is_alloc) begin
                tag_mem[wr_idx] <= wr_tag;
                ctr_mem[wr_idx] <= upd.ctr_new[BANK_ID];
            end
            if (is_alloc || (is_prov && ctr_zero)) begin
                off_mem[wr_idx] <= upd.offset_new;  // Confidence ran out, take the new target.
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int r = 0; r < ROWS; r++) begin
                u_mem[r] <= '0;
            end
        end else if (upd.clear_u) begin
            for (int r = 0; r < ROWS; r++) begin
                u_mem[r] <= '0;
            end
        end else if (is_alloc) begin
            u_mem[wr_idx] <= '0;
        end else if (upd.wr_en && upd.u_en[BANK_ID]) begin
            u_mem[wr_idx] <= upd.u_new;
        end
    end

endmodule

`default_nettype wire

/* verilog/ittage_hash.sv */
`timescale 1ns/100ps
`default_nettype none

module ittage_hash #(
    parameter int SET_BITS = 6,
    parameter int HIST_LEN = 4
) (
    input  logic [ittage_pkg::PC_BITS-1:0]    pc,
    input  logic [ittage_pkg::GHIST_BITS-1:0] ghist,
    output logic [SET_BITS-1:0]               idx,
    output logic [ittage_pkg::TAG_BITS-1:0]   tag
);

    logic [SET_BITS-1:0]             idx_fold;
    logic [ittage_pkg::TAG_BITS-1:0] tag_fold;
    logic [ittage_pkg::TAG_BITS-1:0] tag_mix;

    // Bit 0 of the history is the newest outcome.
    always_comb begin
        idx_fold = '0;
        tag_fold = '0;
        for (int i = 0; i < HIST_LEN; i++) begin
            idx_fold[i % SET_BITS] ^= ghist[i];
            tag_fold[i % ittage_pkg::TAG_BITS] ^= ghist[i];
        end
    end

    // Index and tag take disjoint PC ranges so they stay uncorrelated.
    assign idx     = idx_fold ^ pc[SET_BITS:1];
    assign tag_mix = tag_fold ^ pc[SET_BITS+ittage_pkg::TAG_BITS:SET_BITS+1];

    // A zero tag marks an empty row, so a computed zero is moved to one.
    assign tag = (tag_mix == '0) ? {{(ittage_pkg::TAG_BITS-1){1'b0}}, 1'b1} : tag_mix;

endmodule

`default_nettype wire

/* verilog/ittage_pkg.sv */
`default_nettype none

package ittage_pkg;

    parameter int NUM_BANKS   = 4;
    parameter int PC_BITS     = 32;
    parameter int GHIST_BITS  = 64;
    parameter int TAG_BITS    = 9;
    parameter int CTR_BITS    = 2;
    parameter int U_BITS      = 2;
    parameter int OFFSET_BITS = 20;  // A target is this offset followed by a zero bit.
    parameter int RESETU_BITS = 6;

    // Only the two indirect kinds train the predictor.
    typedef enum logic [2:0] {
        BR_COND,
        BR_DIRECT,
        BR_INDIRECT,
        BR_IND_CALL,
        BR_RETURN
    } br_kind_e;

    // What one bank returns from a lookup.
    typedef struct packed {
        logic                   hit;
        logic [CTR_BITS-1:0]    ctr;
        logic [U_BITS-1:0]      u;
        logic [OFFSET_BITS-1:0] offset;
    } bank_entry_t;

    // Leaves with a prediction and comes back with its update.
    typedef struct packed {
        logic [NUM_BANKS-1:0]   provider;    // One-hot, all zero when nothing hit.
        logic [CTR_BITS-1:0]    ctr;
        logic [OFFSET_BITS-1:0] offset;
        logic [OFFSET_BITS-1:0] alt_offset;
        logic [NUM_BANKS-1:0]   u_busy;      // Set where the read row has nonzero usefulness.
    } ittage_meta_t;

endpackage

`default_nettype wire

/* verilog/ittage_select.sv */
`timescale 1ns/100ps
`default_nettype none

module ittage_select #(
    parameter int NUM_BANKS = ittage_pkg::NUM_BANKS
) (
    input  logic                                    clk,
    input  logic                                    rst,
    input  logic                                    valid_in,
    input  ittage_pkg::bank_entry_t [NUM_BANKS-1:0] entries,
    output logic                                    pred_valid,
    output logic                                    pred_hit,
    output logic [ittage_pkg::PC_BITS-1:0]          pred_target,
    output ittage_pkg::ittage_meta_t                pred_meta
);

    localparam int TGT_PAD = ittage_pkg::PC_BITS - ittage_pkg::OFFSET_BITS - 1;

    logic                               s1_valid;
    logic                               prov_found;
    logic                               alt_found;
    logic [NUM_BANKS-1:0]               prov_oh;
    logic [NUM_BANKS-1:0]               busy;
    ittage_pkg::bank_entry_t            prov_entry;
    logic [ittage_pkg::OFFSET_BITS-1:0] alt_offset;

    // Walk from the longest history down; first hit provides, second is the alternate.
    always_comb begin
        prov_found = 1'b0;
        alt_found  = 1'b0;
        prov_oh    = '0;
        prov_entry = '0;
        alt_offset = '0;
        for (int b = NUM_BANKS - 1; b >= 0; b--) begin
            busy[b] = (entries[b].u != '0);
            if (entries[b].hit && !prov_found) begin
                prov_found = 1'b1;
                prov_oh[b] = 1'b1;
                prov_entry = entries[b];
            end else if (entries[b].hit && !alt_found) begin
                alt_found  = 1'b1;
                alt_offset = entries[b].offset;
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            s1_valid   <= 1'b0;
            pred_valid <= 1'b0;
        end else begin
            s1_valid   <= valid_in;  // Bank rows are registered at this stage.
            pred_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (s1_valid) begin
            pred_hit             <= prov_found;
            pred_target          <= {{TGT_PAD{1'b0}}, prov_entry.offset, 1'b0};
            pred_meta.provider   <= prov_oh;
            pred_meta.ctr        <= prov_entry.ctr;
            pred_meta.offset     <= prov_entry.offset;
            pred_meta.alt_offset <= alt_offset;
            pred_meta.u_busy     <= busy;
        end
    end

endmodule

`default_nettype wire

/* verilog/ittage_update.sv */
`timescale 1ns/100ps
`default_nettype none

module ittage_update #(
    parameter int NUM_BANKS = ittage_pkg::NUM_BANKS
) (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           update_valid,
    input  ittage_pkg::br_kind_e           update_kind,
    input  logic                           update_taken,
    input  logic [ittage_pkg::PC_BITS-1:0] update_target,
    input  ittage_pkg::ittage_meta_t       update_meta,
    ittage_update_if.policy                upd
);

    localparam int TGT_PAD  = ittage_pkg::PC_BITS - ittage_pkg::OFFSET_BITS - 1;
    localparam int CNT_BITS = $clog2(NUM_BANKS + 1);

    logic                               wr_en;
    logic                               indirect;
    logic                               pred_err;
    logic                               alt_err;
    logic                               prov_busy;
    logic                               seen;
    logic [ittage_pkg::CTR_BITS-1:0]    ctr_step;
    logic [ittage_pkg::U_BITS-1:0]      u_base;
    logic [ittage_pkg::U_BITS-1:0]      u_step;
    logic [NUM_BANKS-1:0]               above;
    logic [NUM_BANKS-1:0]               cand;
    logic [NUM_BANKS-1:0]               alloc_sel;
    logic [CNT_BITS-1:0]                busy_cnt;
    logic [ittage_pkg::RESETU_BITS-1:0] resetu_ctr;

    assign indirect = (update_kind == ittage_pkg::BR_INDIRECT) ||
                      (update_kind == ittage_pkg::BR_IND_CALL);
    assign wr_en    = update_valid & update_taken & indirect;
    assign pred_err = update_target != {{TGT_PAD{1'b0}}, update_meta.offset, 1'b0};
    assign alt_err  = update_target != {{TGT_PAD{1'b0}}, update_meta.alt_offset, 1'b0};

    always_comb begin
        if (!pred_err) begin
            ctr_step = (update_meta.ctr == '1) ? update_meta.ctr : update_meta.ctr + 1'b1;
        end else begin
            ctr_step = (update_meta.ctr == '0) ? update_meta.ctr : update_meta.ctr - 1'b1;
        end
    end

    // Only the busy bit of the provider comes back, so a busy provider counts as one.
    assign prov_busy = |(update_meta.provider & update_meta.u_busy);
    assign u_base    = {{(ittage_pkg::U_BITS-1){1'b0}}, prov_busy};

    always_comb begin
        if (!pred_err) begin
            u_step = (u_base == '1) ? u_base : u_base + 1'b1;
        end else begin
            u_step = (u_base == '0) ? u_base : u_base - 1'b1;
        end
    end

    // Banks strictly above the provider, or all banks when nothing hit.
    always_comb begin
        above = '0;
        seen  = 1'b0;
        for (int b = 0; b < NUM_BANKS; b++) begin
            above[b] = seen;
            seen     = seen | update_meta.provider[b];
        end
    end

    assign cand      = ~update_meta.u_busy & ((|update_meta.provider) ? above : '1);
    assign alloc_sel = pred_err ? (cand & (~cand + 1'b1)) : '0;  // Lowest free bank.

    always_comb begin
        busy_cnt = '0;
        for (int b = 0; b < NUM_BANKS; b++) begin
            busy_cnt = busy_cnt + CNT_BITS'(update_meta.u_busy[b]);
        end
    end

    assign upd.wr_en      = wr_en;
    assign upd.provider   = update_meta.provider;
    assign upd.alloc      = alloc_sel;
    assign upd.u_new      = u_step;
    assign upd.offset_new = update_target[ittage_pkg::OFFSET_BITS:1];

    generate
        for (genvar b = 0; b < NUM_BANKS; b++) begin : g_per_bank
            assign upd.ctr_new[b] = alloc_sel[b] ? ittage_pkg::CTR_BITS'(1) : ctr_step;
            assign upd.u_en[b]    = update_meta.provider[b] & (pred_err ^ alt_err);
        end
    endgenerate

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            resetu_ctr  <= '0;
            upd.clear_u <= 1'b0;
        end else begin
            if (resetu_ctr == '1) begin
                resetu_ctr <= '0;
            end else if (wr_en && pred_err) begin
                if (busy_cnt < CNT_BITS'(NUM_BANKS / 2)) begin
                    resetu_ctr <= resetu_ctr - 1'b1;  // Few busy rows, so aging is less urgent.
                end else begin
                    resetu_ctr <= resetu_ctr + 1'b1;
                end
            end
            upd.clear_u <= (resetu_ctr == '1);
        end
    end

endmodule

`default_nettype wire

/* verilog/ittage_update_if.sv */
`timescale 1ns/100ps
`default_nettype none

interface ittage_update_if #(
    parameter int NUM_BANKS = ittage_pkg::NUM_BANKS
);

    logic                                           wr_en;
    logic [NUM_BANKS-1:0]                           provider;
    logic [NUM_BANKS-1:0]                           alloc;
    logic [NUM_BANKS-1:0][ittage_pkg::CTR_BITS-1:0] ctr_new;  // Per bank, since provider and
                                                              // new entry differ.
    logic [NUM_BANKS-1:0]                           u_en;
    logic [ittage_pkg::U_BITS-1:0]                  u_new;
    logic [ittage_pkg::OFFSET_BITS-1:0]             offset_new;
    logic                                           clear_u;

    modport policy (
        output wr_en, provider, alloc, ctr_new, u_en, u_new, offset_new, clear_u
    );

    modport bank (
        input wr_en, provider, alloc, ctr_new, u_en, u_new, offset_new, clear_u
    );

endinterface

`default_nettype wire
